// ==== project.f ====
src/puf_pkg.sv
src/measurement_control.sv
src/ro_edge_counter.sv
src/pair_comparator.sv
src/puf_top.sv
verification/clock_gen.sv
verification/puf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module puf_tb -f project.f -o puf_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/puf_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log \
    && echo "Run passed" \
    || { echo "Run failed, see sim.log"; exit 1; }

// ==== src/measurement_control.sv ====
`timescale 1ns/1ps

module measurement_control #(
    parameter puf_pkg::timer_t idle_cycles    = 500,
    parameter puf_pkg::timer_t settle_cycles  = 100,
    parameter puf_pkg::timer_t measure_cycles = 10000,
    parameter puf_pkg::timer_t hold_cycles    = 100
) (
    input  logic fpga_clk,
    input  logic before_compare_reset,
    output logic count_enable,
    output logic count_clear,
    output logic compare
);

    import puf_pkg::*;

    phase_t phase;
    timer_t timer;
    timer_t phase_len;
    logic   phase_end;

    // Length of the current phase in cycles
    always_comb begin
        case (phase)
            phase_idle:    phase_len = idle_cycles;
            phase_settle:  phase_len = settle_cycles;
            phase_measure: phase_len = measure_cycles;
            default:       phase_len = hold_cycles;
        endcase
    end

    assign phase_end = (timer == timer_t'(phase_len - 1'b1));

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge fpga_clk) begin
        if (before_compare_reset) begin
            phase        <= phase_idle;
            timer        <= '0;
            count_enable <= 1'b0;
            count_clear  <= 1'b0;
            compare      <= 1'b0;
        end else begin
            // Strobes last a single cycle
            count_clear <= 1'b0;
            compare     <= 1'b0;

            if (phase_end) begin
                timer <= '0;
                case (phase)
                    phase_idle: begin
                        phase        <= phase_settle;
                        count_enable <= 1'b1;
                    end
                    phase_settle: begin
                        // Drop whatever counted while the rings settled
                        phase       <= phase_measure;
                        count_clear <= 1'b1;
                    end
                    phase_measure: begin
                        phase   <= phase_hold;
                        compare <= 1'b1;
                    end
                    default: begin
                        phase        <= phase_idle;
                        count_enable <= 1'b0;
                    end
                endcase
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Clear and compare come from different phase ends
    assert property (@(posedge fpga_clk) disable iff (before_compare_reset)
        !(count_clear && compare));

    // Strobes only ever fire inside the enabled window
    assert property (@(posedge fpga_clk) disable iff (before_compare_reset)
        (count_clear || compare) |-> count_enable);

    // Compare follows clear by exactly the measure window
    assert property (@(posedge fpga_clk) disable iff (before_compare_reset)
        count_clear |-> ##(measure_cycles) compare);

endmodule

// ==== src/pair_comparator.sv ====
`timescale 1ns/1ps

module pair_comparator #(
    parameter int                    num_pairs      = 4,
    parameter logic [num_pairs-1:0]  pair_swap_mask = 1
) (
    input  logic                  fpga_clk,
    input  logic                  before_compare_reset,
    input  logic                  compare,
    input  puf_pkg::count_t       counts [2*num_pairs],
    output logic [num_pairs-1:0]  response,
    output logic                  response_valid
);

    logic [num_pairs-1:0] pair_bit;

    ////////////////////
    // Pair decisions
    ////////////////////

    // Odd ring must be faster when the mask bit is set
    // Even ring must be faster when it is clear
    // Ties give 0 either way
    always_comb begin
        for (int i = 0; i < num_pairs; i++) begin
            if (pair_swap_mask[i]) begin
                pair_bit[i] = (counts[2*i+1] > counts[2*i]);
            end else begin
                pair_bit[i] = (counts[2*i] > counts[2*i+1]);
            end
        end
    end

    ////////////////////
    // Response register
    ////////////////////

    always_ff @(posedge fpga_clk) begin
        if (before_compare_reset) begin
            response       <= '0;
            response_valid <= 1'b0;
        end else begin
            response_valid <= compare;
            // Hold until the next round
            if (compare) begin
                response <= pair_bit;
            end
        end
    end

    // Valid marks only the cycle after a compare strobe
    assert property (@(posedge fpga_clk) disable iff (before_compare_reset)
        response_valid |-> $past(compare));

endmodule

// ==== src/puf_pkg.sv ====
package puf_pkg;

    ////////////////////
    // Counter sizing
    ////////////////////

    // Edge count of one oscillator over one window
    parameter int COUNT_WIDTH = 16;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    ////////////////////
    // Phase timing
    ////////////////////

    // Cycle timer, also the type of every phase length
    parameter int TIMER_WIDTH = 16;

    typedef logic [TIMER_WIDTH-1:0] timer_t;

    // Measurement sequence, repeats without end
    typedef enum logic [1:0] {
        phase_idle    = 2'd0,
        phase_settle  = 2'd1,
        phase_measure = 2'd2,
        phase_hold    = 2'd3
    } phase_t;

endpackage

// ==== src/puf_top.sv ====
`timescale 1ns/1ps

module puf_top #(
    parameter int                    num_pairs      = 4,
    parameter puf_pkg::timer_t       idle_cycles    = 500,
    parameter puf_pkg::timer_t       settle_cycles  = 100,
    parameter puf_pkg::timer_t       measure_cycles = 10000,
    parameter puf_pkg::timer_t       hold_cycles    = 100,
    parameter logic [num_pairs-1:0]  pair_swap_mask = 1
) (
    input  logic                    fpga_clk,
    input  logic                    before_compare_reset,
    input  logic [2*num_pairs-1:0]  ro_tap,
    output logic [num_pairs-1:0]    response,
    output logic                    response_valid,
    output logic                    measuring
);

    import puf_pkg::*;

    logic   count_enable;
    logic   count_clear;
    logic   compare;
    count_t counts [2*num_pairs];

    ////////////////////
    // Phase sequencer
    ////////////////////

    measurement_control #(
        .idle_cycles    (idle_cycles),
        .settle_cycles  (settle_cycles),
        .measure_cycles (measure_cycles),
        .hold_cycles    (hold_cycles)
    ) u_control (
        .fpga_clk             (fpga_clk),
        .before_compare_reset (before_compare_reset),
        .count_enable         (count_enable),
        .count_clear          (count_clear),
        .compare              (compare)
    );

    assign measuring = count_enable;

    ////////////////////
    // One counter per ring
    ////////////////////

    for (genvar r = 0; r < 2*num_pairs; r++) begin : g_ring
        ro_edge_counter u_counter (
            .fpga_clk             (fpga_clk),
            .before_compare_reset (before_compare_reset),
            .ro_tap_bit           (ro_tap[r]),
            .count_enable         (count_enable),
            .count_clear          (count_clear),
            .count                (counts[r])
        );
    end

    // Rings 2i and 2i+1 form pair i
    pair_comparator #(
        .num_pairs      (num_pairs),
        .pair_swap_mask (pair_swap_mask)
    ) u_comparator (
        .fpga_clk             (fpga_clk),
        .before_compare_reset (before_compare_reset),
        .compare              (compare),
        .counts               (counts),
        .response             (response),
        .response_valid       (response_valid)
    );

endmodule

// ==== src/ro_edge_counter.sv ====
`timescale 1ns/1ps

module ro_edge_counter (
    input  logic             fpga_clk,
    input  logic             before_compare_reset,
    input  logic             ro_tap_bit,
    input  logic             count_enable,
    input  logic             count_clear,
    output puf_pkg::count_t  count
);

    logic sync_meta;
    logic sync_stable;
    logic sync_prev;
    logic edge_seen;

    ////////////////////
    // Tap synchronizer
    ////////////////////

    // Oscillator tap is asynchronous to fpga_clk
    always_ff @(posedge fpga_clk) begin
        if (before_compare_reset) begin
            sync_meta   <= 1'b0;
            sync_stable <= 1'b0;
        end else begin
            sync_meta   <= ro_tap_bit;
            sync_stable <= sync_meta;
        end
    end

    // Registered rising edge detect
    always_ff @(posedge fpga_clk) begin
        if (before_compare_reset) begin
            sync_prev <= 1'b0;
            edge_seen <= 1'b0;
        end else begin
            sync_prev <= sync_stable;
            edge_seen <= sync_stable & ~sync_prev;
        end
    end

    ////////////////////
    // Edge count
    ////////////////////

    always_ff @(posedge fpga_clk) begin
        if (before_compare_reset) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0;
        end else if (count_enable && edge_seen) begin
            // Wraps at full scale
            count <= count + 1'b1;
        end
    end

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 5
) (
    output logic fpga_clk,
    output logic before_compare_reset
);

    initial begin
        fpga_clk = 1'b0;
        forever #(half_period) fpga_clk = ~fpga_clk;
    end

    // Reset held over the first few rising edges
    initial begin
        before_compare_reset = 1'b1;
        repeat (reset_cycles) @(posedge fpga_clk);
        before_compare_reset <= 1'b0;
    end

endmodule

// ==== verification/puf_tb.sv ====
`timescale 1ns/1ps

module puf_tb;

    import puf_pkg::*;

    localparam int                   num_pairs      = 4;
    localparam timer_t               idle_cycles    = 20;
    localparam timer_t               settle_cycles  = 10;
    localparam timer_t               measure_cycles = 60;
    localparam timer_t               hold_cycles    = 10;
    localparam logic [num_pairs-1:0] swap_mask      = 4'b0101;
    localparam int                   num_taps       = 2 * num_pairs;

    localparam int reset_cycles   = 5;
    localparam int num_rounds     = 5;
    localparam int round_cycles   = idle_cycles + settle_cycles + measure_cycles + hold_cycles;
    localparam int timeout_cycles = num_rounds * round_cycles + reset_cycles + 100;
    localparam int wait_limit     = round_cycles + 10;

    // First measure-phase tap edge lands here, counted from the window start
    localparam int measure_lead = 14;

    logic                 fpga_clk;
    logic                 before_compare_reset;
    logic [num_taps-1:0]  ro_tap;
    logic [num_pairs-1:0] response;
    logic                 response_valid;
    logic                 measuring;

    int                   error_count = 0;
    int                   check_count = 0;
    int                   cycle_count = 0;
    integer               seed = 32'hb6a8;
    logic [num_pairs-1:0] last_response;

    clock_gen #(
        .half_period  (5),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .fpga_clk             (fpga_clk),
        .before_compare_reset (before_compare_reset)
    );

    puf_top #(
        .num_pairs      (num_pairs),
        .idle_cycles    (idle_cycles),
        .settle_cycles  (settle_cycles),
        .measure_cycles (measure_cycles),
        .hold_cycles    (hold_cycles),
        .pair_swap_mask (swap_mask)
    ) dut (
        .fpga_clk             (fpga_clk),
        .before_compare_reset (before_compare_reset),
        .ro_tap               (ro_tap),
        .response             (response),
        .response_valid       (response_valid),
        .measuring            (measuring)
    );

    ////////////////////
    // Checks and reporting
    ////////////////////

    task automatic check_response(input logic [num_pairs-1:0] got,
                                  input logic [num_pairs-1:0] exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input timer_t got, input timer_t exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    always @(posedge fpga_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("ERROR: run did not complete within %0d cycles", timeout_cycles);
            error_count++;
            finish_run();
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Mask bit set: odd tap must win. Clear: even tap must win. Ties give 0
    function automatic logic [num_pairs-1:0] expected_response(input count_t edges [num_taps]);
        logic [num_pairs-1:0] bits;
        for (int i = 0; i < num_pairs; i++) begin
            if (swap_mask[i]) begin
                bits[i] = edges[2*i+1] > edges[2*i];
            end else begin
                bits[i] = edges[2*i] > edges[2*i+1];
            end
        end
        return bits;
    endfunction

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // All taps pulse in parallel, 2 cycles high then 2 low per edge
    task automatic drive_edges(input count_t edges [num_taps]);
        int                  max_edges;
        logic [num_taps-1:0] level;
        max_edges = 0;
        for (int t = 0; t < num_taps; t++) begin
            if (int'(edges[t]) > max_edges) begin
                max_edges = int'(edges[t]);
            end
        end
        for (int k = 0; k < max_edges; k++) begin
            for (int t = 0; t < num_taps; t++) begin
                level[t] = (k < int'(edges[t]));
            end
            @(posedge fpga_clk);
            ro_tap <= level;
            @(posedge fpga_clk);
            @(posedge fpga_clk);
            ro_tap <= '0;
            @(posedge fpga_clk);
        end
    endtask

    task automatic random_edges(input int max_edges, output count_t edges [num_taps]);
        for (int t = 0; t < num_taps; t++) begin
            edges[t] = count_t'({$random(seed)} % (max_edges + 1));
        end
    endtask

    // Outputs are sampled on the falling edge
    task automatic wait_measuring(input logic level, output timer_t waited);
        waited = 0;
        do begin
            @(negedge fpga_clk);
            waited++;
        end while (measuring !== level && waited < wait_limit);
        if (measuring !== level) begin
            error_count++;
            $display("ERROR: measuring did not go to %0b within %0d cycles", level, wait_limit);
        end
    endtask

    task automatic wait_valid(output timer_t waited);
        waited = 0;
        do begin
            @(negedge fpga_clk);
            waited++;
        end while (response_valid !== 1'b1 && waited < wait_limit);
        if (response_valid !== 1'b1) begin
            error_count++;
            $display("ERROR: no response_valid pulse within %0d cycles", wait_limit);
        end
    endtask

    // Returns on the falling edge right after measuring rises
    task automatic wait_window_start();
        timer_t waited;
        wait_measuring(1'b0, waited);
        wait_measuring(1'b1, waited);
    endtask

    task automatic collect_response(input logic [num_pairs-1:0] exp);
        timer_t waited;
        wait_valid(waited);
        check_response(response, exp, "response");
        last_response = exp;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_state();
        int waited;
        waited = 0;
        do begin
            @(negedge fpga_clk);
            waited++;
        end while (before_compare_reset && waited < wait_limit);
        check_bit(measuring, 1'b0, "measuring");
        check_bit(response_valid, 1'b0, "response_valid");
        check_response(response, '0, "response");
    endtask

    // Starts on the first falling edge after reset release
    task automatic test_phase_timing();
        timer_t waited;
        wait_measuring(1'b1, waited);
        check_cycles(waited, idle_cycles, "cycles to measuring rise");
        wait_valid(waited);
        check_cycles(waited, timer_t'(settle_cycles + measure_cycles + 1),
                     "cycles to response_valid");
        // Quiet taps tie in every pair
        check_response(response, '0, "response");
        @(negedge fpga_clk);
        check_bit(response_valid, 1'b0, "response_valid");
        wait_measuring(1'b0, waited);
        // One cycle already spent on the pulse width check
        check_cycles(timer_t'(waited + 1), timer_t'(hold_cycles - 1),
                     "cycles to measuring fall");
        last_response = '0;
    endtask

    task automatic test_pair_decision();
        count_t edges [num_taps];
        edges = '{2, 6, 9, 4, 7, 3, 1, 8};
        wait_window_start();
        repeat (measure_lead) @(posedge fpga_clk);
        drive_edges(edges);
        collect_response(expected_response(edges));
    endtask

    task automatic test_ties_and_settle();
        count_t settle_edges [num_taps];
        count_t edges [num_taps];
        // Extra settle edges on the tap that would win each pair
        settle_edges = '{0, 2, 2, 0, 0, 2, 2, 0};
        edges = '{4, 4, 5, 5, 3, 3, 6, 6};
        wait_window_start();
        drive_edges(settle_edges);
        repeat (measure_lead - 8) @(posedge fpga_clk);
        drive_edges(edges);
        collect_response(expected_response(edges));
    endtask

    task automatic test_idle_and_repeat();
        count_t idle_edges [num_taps];
        count_t edges [num_taps];
        timer_t waited;
        random_edges(3, idle_edges);
        random_edges(10, edges);
        wait_measuring(1'b0, waited);
        check_response(response, last_response, "held response");
        drive_edges(idle_edges);
        wait_measuring(1'b1, waited);
        repeat (measure_lead) @(posedge fpga_clk);
        drive_edges(edges);
        collect_response(expected_response(edges));
    endtask

    initial begin
        ro_tap = '0;
        last_response = '0;
        test_reset_state();
        test_phase_timing();
        test_pair_decision();
        test_ties_and_settle();
        test_idle_and_repeat();
        test_idle_and_repeat();
        finish_run();
    end

endmodule
